/* common/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register file sizes
`define XLEN       32
`define REG_COUNT  32
`define REG_IDX_W  5

`define DMEM_WORDS 256
`define RESET_PC   32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR  32'h0000_0013

// rv32i major opcodes, kept subset only
`define OPC_LUI    7'b0110111
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111

`endif

/* common/cpuPkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package cpuPkg;

  typedef logic [`XLEN-1:0]      word_t;
  typedef logic [`REG_IDX_W-1:0] regIdx_t;

  typedef enum logic [3:0] {
    ALU_ADD,  // zero value, used by bubbles
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASSB
  } aluOp_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JUMP   // jal and jalr
  } brOp_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK   // pc + 4
  } wbSel_e;

  ////////////////////////////////////////////////////////////////////
  // pipeline payloads

  typedef struct packed {
    aluOp_e aluOp;
    brOp_e  brOp;
    wbSel_e wbSel;
    logic   useImm;   // operand b from imm
    logic   usePc;    // operand a from pc
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetchPkt_t;

  typedef struct packed {
    word_t   pc;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    word_t   rs1Data;
    word_t   rs2Data;
    word_t   imm;
    ctrl_t   ctrl;
  } decPkt_t;

  typedef struct packed {
    word_t   pc;
    regIdx_t rd;
    word_t   aluResult;
    word_t   storeData;
    ctrl_t   ctrl;
  } exPkt_t;

  typedef struct packed {
    logic    valid;
    regIdx_t rd;
    word_t   data;
  } wbPkt_t;

  typedef wbPkt_t retire_t;

endpackage

`default_nettype wire

/* core/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetchStage import cpuPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,
  input  logic      flush,
  input  logic      redirectValid,
  input  word_t     redirectTarget,
  output word_t     imemAddr,
  input  word_t     imemData,
  output fetchPkt_t fetchOut
);

  word_t pc;
  word_t pcNext;

  // redirect wins over a load-use hold
  always_comb begin
    if (redirectValid) begin
      pcNext = redirectTarget;
    end else if (stall) begin
      pcNext = pc;
    end else begin
      pcNext = pc + word_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

  assign imemAddr = pc;  // combinational imem read

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      fetchOut.instr <= `NOP_INSTR;  // wrong-path slot
    end else if (!stall) begin
      fetchOut.pc    <= pc;
      fetchOut.instr <= imemData;
    end
  end

endmodule

`default_nettype wire

/* core/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module decodeStage import cpuPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,
  input  logic      flush,
  input  fetchPkt_t fetchIn,
  output regIdx_t   rs1,
  output regIdx_t   rs2,
  input  word_t     rs1Data,
  input  word_t     rs2Data,
  output decPkt_t   decOut
);

  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      immI, immS, immB, immU, immJ;
  word_t      imm;
  ctrl_t      ctrl;
  aluOp_e     aluFn;
  logic       fnOk;
  logic       opImmOk;
  logic       opOk;

  assign instr  = fetchIn.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];  // raw fields, also to regfile and hazard unit
  assign rs2    = instr[24:20];

  ////////////////////////////////////////////////////////////////////
  // immediates

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // shared funct3 map for op and op-imm
  always_comb begin
    aluFn = ALU_ADD;
    fnOk  = 1'b1;
    case (funct3)
      3'b000:  aluFn = (opcode == `OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  aluFn = ALU_SLL;
      3'b010:  aluFn = ALU_SLT;
      3'b100:  aluFn = ALU_XOR;
      3'b101:  aluFn = ALU_SRL;
      3'b110:  aluFn = ALU_OR;
      3'b111:  aluFn = ALU_AND;
      default: fnOk  = 1'b0;  // sltu
    endcase
  end

  // no shift-immediates in the subset, no sra
  assign opImmOk = fnOk && funct3 != 3'b001 && funct3 != 3'b101;
  assign opOk    = fnOk && (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000));

  ////////////////////////////////////////////////////////////////////
  // control

  always_comb begin
    ctrl = '0;
    imm  = immI;
    case (opcode)
      `OPC_LUI: begin
        imm           = immU;
        ctrl.aluOp    = ALU_PASSB;
        ctrl.useImm   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OPC_OPIMM: if (opImmOk) begin
        ctrl.aluOp    = aluFn;
        ctrl.useImm   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OPC_OP: if (opOk) begin
        ctrl.aluOp    = aluFn;
        ctrl.regWrite = 1'b1;
      end
      `OPC_LOAD: if (funct3 == 3'b010) begin
        ctrl.useImm   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.wbSel    = WB_LOAD;
        ctrl.regWrite = 1'b1;
      end
      `OPC_STORE: if (funct3 == 3'b010) begin
        imm           = immS;
        ctrl.useImm   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      `OPC_BRANCH: begin
        imm = immB;
        case (funct3)
          3'b000:  ctrl.brOp = BR_EQ;
          3'b001:  ctrl.brOp = BR_NE;
          3'b100:  ctrl.brOp = BR_LT;
          3'b101:  ctrl.brOp = BR_GE;
          default: ctrl.brOp = BR_NONE;
        endcase
        ctrl.usePc  = (ctrl.brOp != BR_NONE);  // alu builds pc + imm
        ctrl.useImm = (ctrl.brOp != BR_NONE);
      end
      `OPC_JAL: begin
        imm           = immJ;
        ctrl.usePc    = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.brOp     = BR_JUMP;
        ctrl.wbSel    = WB_LINK;
        ctrl.regWrite = 1'b1;
      end
      `OPC_JALR: if (funct3 == 3'b000) begin
        ctrl.useImm   = 1'b1;
        ctrl.brOp     = BR_JUMP;
        ctrl.wbSel    = WB_LINK;
        ctrl.regWrite = 1'b1;
      end
      default: ;  // executes as nop
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || stall || flush) begin
      decOut.ctrl <= '0;  // bubble
    end else begin
      decOut.pc      <= fetchIn.pc;
      decOut.rs1     <= rs1;
      decOut.rs2     <= rs2;
      decOut.rd      <= instr[11:7];
      decOut.rs1Data <= rs1Data;
      decOut.rs2Data <= rs2Data;
      decOut.imm     <= imm;
      decOut.ctrl    <= ctrl;
    end
  end

endmodule

`default_nettype wire

/* core/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module regFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regIdx_t rs1,
  input  regIdx_t rs2,
  output word_t   rs1Data,
  output word_t   rs2Data,
  input  wbPkt_t  wb
);

  word_t regs [1:`REG_COUNT-1];  // x0 not stored

  function automatic word_t readPort(regIdx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb.valid && wb.rd == idx) begin
      return wb.data;  // write in flight this cycle
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

`default_nettype wire

/* core/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module executeStage import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  decPkt_t decIn,
  input  wbPkt_t  wbFwd,
  output logic    redirectValid,
  output word_t   redirectTarget,
  output exPkt_t  exOut
);

  word_t memFwd;
  word_t src1, src2;
  word_t opA, opB;
  word_t aluResult;

  // what the memory-stage instruction will write back
  assign memFwd = (exOut.ctrl.wbSel == WB_LINK) ? exOut.pc + word_t'(4) : exOut.aluResult;

  // youngest producer first
  function automatic word_t fwdSel(regIdx_t idx, word_t regVal);
    if (exOut.ctrl.regWrite && exOut.rd != '0 && exOut.rd == idx) begin
      return memFwd;
    end else if (wbFwd.valid && wbFwd.rd == idx) begin
      return wbFwd.data;  // valid already excludes x0
    end
    return regVal;
  endfunction

  always_comb begin
    src1 = fwdSel(decIn.rs1, decIn.rs1Data);
    src2 = fwdSel(decIn.rs2, decIn.rs2Data);
  end

  assign opA = decIn.ctrl.usePc  ? decIn.pc  : src1;
  assign opB = decIn.ctrl.useImm ? decIn.imm : src2;

  always_comb begin
    case (decIn.ctrl.aluOp)
      ALU_SUB:   aluResult = opA - opB;
      ALU_AND:   aluResult = opA & opB;
      ALU_OR:    aluResult = opA | opB;
      ALU_XOR:   aluResult = opA ^ opB;
      ALU_SLT:   aluResult = word_t'($signed(opA) < $signed(opB));
      ALU_SLL:   aluResult = opA << opB[4:0];
      ALU_SRL:   aluResult = opA >> opB[4:0];
      ALU_PASSB: aluResult = opB;  // lui
      default:   aluResult = opA + opB;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // branch resolve, redirect is same cycle

  always_comb begin
    case (decIn.ctrl.brOp)
      BR_EQ:   redirectValid = (src1 == src2);
      BR_NE:   redirectValid = (src1 != src2);
      BR_LT:   redirectValid = ($signed(src1) < $signed(src2));
      BR_GE:   redirectValid = ($signed(src1) >= $signed(src2));
      BR_JUMP: redirectValid = 1'b1;
      default: redirectValid = 1'b0;
    endcase
  end

  // jalr needs bit 0 cleared, other targets are already even
  assign redirectTarget = {aluResult[`XLEN-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (rst) begin
      exOut.ctrl <= '0;
    end else begin
      exOut.pc        <= decIn.pc;
      exOut.rd        <= decIn.rd;
      exOut.aluResult <= aluResult;
      exOut.storeData <= src2;
      exOut.ctrl      <= decIn.ctrl;
    end
  end

endmodule

`default_nettype wire

/* core/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
  input  regIdx_t rs1,
  input  regIdx_t rs2,
  input  decPkt_t decIn,
  input  logic    redirectValid,
  output logic    stall,
  output logic    flush
);

  logic loadUse;

  // load in execute feeding the instruction in decode
  assign loadUse = decIn.ctrl.memRead && decIn.rd != '0 &&
                   (decIn.rd == rs1 || decIn.rd == rs2);

  // decode slot is squashed anyway on a redirect
  assign flush = redirectValid;
  assign stall = loadUse && !redirectValid;

endmodule

`default_nettype wire

/* logic/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module memStage import cpuPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  exPkt_t exIn,
  output wbPkt_t wbOut
);

  localparam int AddrW = $clog2(`DMEM_WORDS);

  word_t            dmem [`DMEM_WORDS];
  logic [AddrW-1:0] wordAddr;
  word_t            loadData;
  word_t            wbData;

  assign wordAddr = exIn.aluResult[AddrW+1:2];  // word aligned only
  assign loadData = exIn.ctrl.memRead ? dmem[wordAddr] : '0;

  always_ff @(posedge clk) begin
    if (exIn.ctrl.memWrite) begin
      dmem[wordAddr] <= exIn.storeData;
    end
  end

  always_comb begin
    case (exIn.ctrl.wbSel)
      WB_LOAD: wbData = loadData;
      WB_LINK: wbData = exIn.pc + word_t'(4);
      default: wbData = exIn.aluResult;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wbOut.valid <= 1'b0;
    end else begin
      wbOut.valid <= exIn.ctrl.regWrite && exIn.rd != '0;
      wbOut.rd    <= exIn.rd;
      wbOut.data  <= wbData;
    end
  end

endmodule

`default_nettype wire

/* core/cpuCore.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  output word_t   imemAddr,
  input  word_t   imemData,
  output retire_t retire
);

  fetchPkt_t fetchPkt;
  decPkt_t   decPkt;
  exPkt_t    exPkt;
  wbPkt_t    wbPkt;
  regIdx_t   rs1;
  regIdx_t   rs2;
  word_t     rs1Data;
  word_t     rs2Data;
  logic      redirectValid;
  word_t     redirectTarget;
  logic      stall;
  logic      flush;

  fetchStage uFetch (
    .clk            (clk),
    .rst            (rst),
    .stall          (stall),
    .flush          (flush),
    .redirectValid  (redirectValid),
    .redirectTarget (redirectTarget),
    .imemAddr       (imemAddr),
    .imemData       (imemData),
    .fetchOut       (fetchPkt)
  );

  decodeStage uDecode (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .flush   (flush),
    .fetchIn (fetchPkt),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .decOut  (decPkt)
  );

  regFile uRegs (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wb      (wbPkt)
  );

  executeStage uExecute (
    .clk            (clk),
    .rst            (rst),
    .decIn          (decPkt),
    .wbFwd          (wbPkt),       // writeback-stage forwarding source
    .redirectValid  (redirectValid),
    .redirectTarget (redirectTarget),
    .exOut          (exPkt)
  );

  hazardUnit uHazard (
    .rs1           (rs1),
    .rs2           (rs2),
    .decIn         (decPkt),
    .redirectValid (redirectValid),
    .stall         (stall),
    .flush         (flush)
  );

  memStage uMem (
    .clk   (clk),
    .rst   (rst),
    .exIn  (exPkt),
    .wbOut (wbPkt)
  );

  assign retire = wbPkt;

endmodule

`default_nettype wire

/* dv/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuTb import cpuPkg::*; ();

  localparam word_t   SelfLoop      = 32'h0000_006f;  // jal x0, 0
  localparam regIdx_t WrongPathRd   = 5'd31;          // only written by squashed slots
  localparam int      RetireTimeout = 600;
  localparam int      ModelSteps    = 4000;
  localparam int      MemAw         = $clog2(`DMEM_WORDS);

  logic    clk;
  logic    rst = 1'b1;
  word_t   imemData = `NOP_INSTR;
  word_t   imemAddr;
  retire_t retire;

  word_t  prog [$];     // program image, word index = pc / 4
  wbPkt_t expQ [$];     // expected retire stream from the ISA model
  word_t  modelMem [`DMEM_WORDS];  // persists across tests, like the DUT array
  integer seed = 32'h72fa_dce3;
  int     errors = 0;
  int     passCount = 0;
  int     failCount = 0;
  logic   afterReset = 1'b1;

  cpuCore DUT (
    .clk      (clk),
    .rst      (rst),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .retire   (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // program image and instruction encoders

  function automatic word_t progWord(word_t addr);
    logic [29:0] idx;
    idx = addr[31:2];
    if (idx < prog.size()) begin
      return prog[idx];
    end
    return `NOP_INSTR;  // past the end
  endfunction

  // instruction port, updated on the falling edge
  always @(negedge clk) begin
    imemData <= progWord(imemAddr);
  end

  function automatic word_t rType(logic [6:0] f7, regIdx_t rs2, regIdx_t rs1,
                                  logic [2:0] f3, regIdx_t rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic word_t iType(logic [11:0] imm, regIdx_t rs1, logic [2:0] f3,
                                  regIdx_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t sType(logic [11:0] imm, regIdx_t rs2, regIdx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};  // sw
  endfunction

  function automatic word_t bType(logic [12:0] off, regIdx_t rs2, regIdx_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic word_t uType(logic [19:0] imm, regIdx_t rd);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic word_t jType(logic [20:0] off, regIdx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  task automatic emit(input word_t instr);
    prog.push_back(instr);
  endtask

  // two slots behind a taken transfer, never architecturally executed
  task automatic shadowPair();
    emit(iType(12'h7ff, 5'd0, 3'b000, WrongPathRd, `OPC_OPIMM));
    emit(iType(12'h5a5, 5'd0, 3'b100, WrongPathRd, `OPC_OPIMM));
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequential ISA model of the kept subset

  function automatic void interpret();
    word_t   regs [`REG_COUNT];
    word_t   pc, nextPc, instr, a, b, val, addr;
    word_t   immI, immS, immB, immJ;
    logic    [2:0] f3;
    logic    [6:0] f7;
    logic    write, taken;
    regIdx_t rd;
    wbPkt_t  w;
    int      steps;
    for (int i = 0; i < `REG_COUNT; i++) begin
      regs[i] = '0;
    end
    pc = `RESET_PC;
    for (steps = 0; steps < ModelSteps; steps++) begin
      instr = progWord(pc);
      if (instr == SelfLoop) break;
      rd     = instr[11:7];
      f3     = instr[14:12];
      f7     = instr[31:25];
      a      = regs[instr[19:15]];
      b      = regs[instr[24:20]];
      immI   = {{20{instr[31]}}, instr[31:20]};
      immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      immB   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      immJ   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      nextPc = pc + 4;
      write  = 1'b0;
      val    = '0;
      case (instr[6:0])
        `OPC_LUI: begin
          write = 1'b1;
          val   = {instr[31:12], 12'b0};
        end
        `OPC_OPIMM: begin
          write = 1'b1;
          case (f3)
            3'b000:  val = a + immI;
            3'b010:  val = {31'b0, $signed(a) < $signed(immI)};
            3'b100:  val = a ^ immI;
            3'b110:  val = a | immI;
            3'b111:  val = a & immI;
            default: write = 1'b0;
          endcase
        end
        `OPC_OP: begin
          write = 1'b1;
          if (f7 == 7'h20 && f3 == 3'b000) begin
            val = a - b;
          end else if (f7 != 7'h00) begin
            write = 1'b0;
          end else begin
            case (f3)
              3'b000:  val = a + b;
              3'b001:  val = a << b[4:0];
              3'b010:  val = {31'b0, $signed(a) < $signed(b)};
              3'b100:  val = a ^ b;
              3'b101:  val = a >> b[4:0];
              3'b110:  val = a | b;
              3'b111:  val = a & b;
              default: write = 1'b0;  // sltu not kept
            endcase
          end
        end
        `OPC_LOAD: if (f3 == 3'b010) begin
          addr  = a + immI;
          val   = modelMem[addr[MemAw+1:2]];
          write = 1'b1;
        end
        `OPC_STORE: if (f3 == 3'b010) begin
          addr = a + immS;
          modelMem[addr[MemAw+1:2]] = b;
        end
        `OPC_BRANCH: begin
          case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            default: taken = 1'b0;
          endcase
          if (taken) nextPc = pc + immB;
        end
        `OPC_JAL: begin
          write  = 1'b1;
          val    = pc + 4;
          nextPc = pc + immJ;
        end
        `OPC_JALR: if (f3 == 3'b000) begin
          write  = 1'b1;
          val    = pc + 4;
          nextPc = (a + immI) & ~word_t'(1);
        end
        default: ;
      endcase
      if (write && rd != '0) begin
        regs[rd] = val;
        w.valid  = 1'b1;
        w.rd     = rd;
        w.data   = val;
        expQ.push_back(w);
      end
      pc = nextPc;
    end
    if (steps == ModelSteps) begin
      $display("reference model never reached the closing self-loop");
      errors++;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // retire checks, sampled on the falling edge

  always @(negedge clk) begin : checkRetire
    wbPkt_t exp;
    assert (!(rst || afterReset) || !retire.valid) else begin
      $display("retire.valid was high during reset or in the cycle right after it");
      errors++;
    end
    // fetch held at the reset vector
    assert (!rst || imemAddr == `RESET_PC) else begin
      $display("[FAIL] imemAddr expected 0x%h got 0x%h", `RESET_PC, imemAddr);
      errors++;
    end
    afterReset = rst;
    if (!rst && retire.valid) begin
      assert (retire.rd != '0) else begin
        $display("a retire was reported with rd x0");
        errors++;
      end
      assert (retire.rd != WrongPathRd) else begin
        $display("an instruction behind a taken transfer retired");
        errors++;
      end
      if (expQ.size() == 0) begin
        $display("retire seen while no register write was expected");
        errors++;
      end else begin
        exp = expQ.pop_front();
        assert (retire.rd == exp.rd) else begin
          $display("[FAIL] retire.rd expected 0x%h got 0x%h", exp.rd, retire.rd);
          errors++;
        end
        assert (retire.data == exp.data) else begin
          $display("[FAIL] retire.data expected 0x%h got 0x%h", exp.data, retire.data);
          errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequencing

  // core held in reset while the next program is loaded
  task automatic holdReset();
    @(negedge clk);
    rst <= 1'b1;
    @(negedge clk);
    prog.delete();
    expQ.delete();
  endtask

  task automatic execTest(input string name);
    int errBefore;
    int cycles;
    errBefore = errors;
    emit(SelfLoop);
    interpret();
    repeat (3) @(negedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (expQ.size() != 0 && cycles < RetireTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (expQ.size() != 0) begin
      $display("%s: expected register writes did not all retire, %0d left after %0d cycles",
               name, expQ.size(), cycles);
      errors++;
    end
    repeat (8) @(negedge clk);  // window for stray retires
    if (errors == errBefore) begin
      passCount++;
      $display("test %-8s passed", name);
    end else begin
      failCount++;
      $display("test %-8s failed with %0d errors", name, errors - errBefore);
    end
  endtask

  initial begin : stimulus
    regIdx_t rd, rs1, rs2, prev, older;
    word_t   imm;
    int      at;

    // reset, first retire must be x5
    holdReset();
    emit(iType(12'h123, 5'd0, 3'b000, 5'd5, `OPC_OPIMM));
    emit(iType(12'h001, 5'd5, 3'b000, 5'd6, `OPC_OPIMM));
    execTest("reset");

    // every alu kind, sources x1..x6 never rewritten
    holdReset();
    for (int i = 1; i <= 6; i++) emit(uType(20'($random(seed)), regIdx_t'(i)));
    for (int i = 1; i <= 6; i++) emit(iType(12'($random(seed)), regIdx_t'(i), 3'b110,
                                            regIdx_t'(i), `OPC_OPIMM));
    for (int k = 0; k < 28; k++) begin
      rd  = regIdx_t'(10 + k % 16);
      rs1 = regIdx_t'(1 + {$random(seed)} % 6);
      rs2 = regIdx_t'(1 + {$random(seed)} % 6);
      imm = $random(seed);
      case (k % 14)
        0:  emit(rType(7'h00, rs2, rs1, 3'b000, rd));
        1:  emit(rType(7'h20, rs2, rs1, 3'b000, rd));
        2:  emit(rType(7'h00, rs2, rs1, 3'b111, rd));
        3:  emit(rType(7'h00, rs2, rs1, 3'b110, rd));
        4:  emit(rType(7'h00, rs2, rs1, 3'b100, rd));
        5:  emit(rType(7'h00, rs2, rs1, 3'b010, rd));
        6:  emit(rType(7'h00, rs2, rs1, 3'b001, rd));
        7:  emit(rType(7'h00, rs2, rs1, 3'b101, rd));
        8:  emit(iType(imm[11:0], rs1, 3'b000, rd, `OPC_OPIMM));
        9:  emit(iType(imm[11:0], rs1, 3'b111, rd, `OPC_OPIMM));
        10: emit(iType(imm[11:0], rs1, 3'b110, rd, `OPC_OPIMM));
        11: emit(iType(imm[11:0], rs1, 3'b100, rd, `OPC_OPIMM));
        12: emit(iType(imm[11:0], rs1, 3'b010, rd, `OPC_OPIMM));
        default: emit(uType(imm[31:12], rd));
      endcase
    end
    execTest("alu");

    // back-to-back chains at distance one and two
    holdReset();
    emit(iType(12'($random(seed)), 5'd0, 3'b000, 5'd1, `OPC_OPIMM));
    emit(iType(12'($random(seed)), 5'd0, 3'b000, 5'd2, `OPC_OPIMM));
    older = 5'd1;
    prev  = 5'd2;
    for (int k = 0; k < 18; k++) begin
      rd = regIdx_t'(3 + k % 5);
      case (k % 4)
        0: emit(rType(7'h00, older, prev, 3'b000, rd));
        1: emit(rType(7'h20, prev, older, 3'b000, rd));
        2: emit(rType(7'h00, older, prev, 3'b100, rd));
        default: emit(iType(12'($random(seed)), prev, 3'b000, rd, `OPC_OPIMM));
      endcase
      older = prev;
      prev  = rd;
    end
    execTest("forward");

    // stores, then loads with load-use pairs
    holdReset();
    emit(iType(12'h100, 5'd0, 3'b000, 5'd10, `OPC_OPIMM));
    for (int i = 0; i < 6; i++) begin
      emit(uType(20'($random(seed)), 5'd11));
      emit(iType(12'($random(seed)), 5'd11, 3'b000, 5'd11, `OPC_OPIMM));
      emit(sType(12'(4 * i), 5'd11, 5'd10));
    end
    emit(iType(12'd0, 5'd10, 3'b010, 5'd12, `OPC_LOAD));
    emit(rType(7'h00, 5'd12, 5'd12, 3'b000, 5'd13));  // stalls one cycle
    emit(iType(12'd4, 5'd10, 3'b010, 5'd14, `OPC_LOAD));
    emit(iType(12'd8, 5'd10, 3'b010, 5'd15, `OPC_LOAD));
    emit(rType(7'h00, 5'd15, 5'd14, 3'b000, 5'd16));
    emit(iType(12'd12, 5'd10, 3'b010, 5'd17, `OPC_LOAD));
    emit(sType(12'd40, 5'd17, 5'd10));  // store data from the load
    emit(iType(12'd40, 5'd10, 3'b010, 5'd18, `OPC_LOAD));
    emit(iType(12'd1, 5'd18, 3'b000, 5'd19, `OPC_OPIMM));
    emit(iType(12'd16, 5'd10, 3'b010, 5'd20, `OPC_LOAD));
    emit(rType(7'h20, 5'd20, 5'd0, 3'b000, 5'd21));
    execTest("memory");

    // branches both ways, jal, jalr, a short loop
    holdReset();
    emit(iType(12'd5, 5'd0, 3'b000, 5'd1, `OPC_OPIMM));
    emit(iType(12'd5, 5'd0, 3'b000, 5'd2, `OPC_OPIMM));
    emit(iType(-12'sd3, 5'd0, 3'b000, 5'd3, `OPC_OPIMM));
    emit(bType(13'd12, 5'd2, 5'd1, 3'b000));  // beq taken
    shadowPair();
    emit(bType(13'd12, 5'd2, 5'd1, 3'b001));  // bne falls through
    emit(iType(12'd11, 5'd0, 3'b000, 5'd4, `OPC_OPIMM));
    emit(iType(12'd12, 5'd0, 3'b000, 5'd5, `OPC_OPIMM));
    emit(bType(13'd12, 5'd1, 5'd3, 3'b100));  // blt taken
    shadowPair();
    emit(bType(13'd12, 5'd1, 5'd3, 3'b101));  // bge falls through
    emit(iType(12'd13, 5'd0, 3'b000, 5'd6, `OPC_OPIMM));
    emit(iType(12'd14, 5'd0, 3'b000, 5'd7, `OPC_OPIMM));
    emit(bType(13'd12, 5'd2, 5'd1, 3'b101));  // bge on equal
    shadowPair();
    emit(bType(13'd12, 5'd1, 5'd3, 3'b001));  // bne taken
    shadowPair();
    emit(bType(13'd12, 5'd3, 5'd1, 3'b100));  // blt falls through
    emit(iType(12'd15, 5'd0, 3'b000, 5'd8, `OPC_OPIMM));
    emit(iType(12'd16, 5'd0, 3'b000, 5'd9, `OPC_OPIMM));
    emit(jType(21'd12, 5'd10));
    shadowPair();
    at = prog.size();
    emit(iType(12'(at * 4 + 16), 5'd0, 3'b000, 5'd12, `OPC_OPIMM));
    emit(iType(12'd1, 5'd12, 3'b000, 5'd13, `OPC_JALR));  // odd sum, bit 0 dropped
    shadowPair();
    emit(iType(12'd3, 5'd0, 3'b000, 5'd14, `OPC_OPIMM));
    emit(iType(12'd2, 5'd15, 3'b000, 5'd15, `OPC_OPIMM));  // loop body
    emit(iType(-12'sd1, 5'd14, 3'b000, 5'd14, `OPC_OPIMM));
    emit(bType(-13'sd8, 5'd0, 5'd14, 3'b001));
    emit(iType(12'd1, 5'd15, 3'b000, 5'd16, `OPC_OPIMM));
    execTest("control");

    // x0 writes are dropped and read back as zero
    holdReset();
    emit(iType(12'd55, 5'd0, 3'b000, 5'd0, `OPC_OPIMM));
    emit(uType(20'($random(seed)), 5'd0));
    emit(iType(12'd7, 5'd0, 3'b000, 5'd1, `OPC_OPIMM));
    emit(rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd2));
    emit(rType(7'h20, 5'd1, 5'd0, 3'b000, 5'd3));
    emit(iType(12'h100, 5'd0, 3'b010, 5'd0, `OPC_LOAD));
    emit(rType(7'h00, 5'd0, 5'd1, 3'b000, 5'd4));
    emit(jType(21'd12, 5'd0));
    shadowPair();
    emit(iType(12'd1, 5'd0, 3'b000, 5'd5, `OPC_OPIMM));
    execTest("x0");

    $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errors);
    if (failCount == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/cpuPkg.sv
core/fetchStage.sv
core/decodeStage.sv
core/regFile.sv
core/executeStage.sv
core/hazardUnit.sv
logic/memStage.sv
core/cpuCore.sv
dv/cpuTb.sv

/* Bender.yml */
package:
  name: rv32i_pipe

export_include_dirs:
  - common

sources:
  - files:
      - common/cpuPkg.sv
      - core/fetchStage.sv
      - core/decodeStage.sv
      - core/regFile.sv
      - core/executeStage.sv
      - core/hazardUnit.sv
      - logic/memStage.sv
      - core/cpuCore.sv
  - target: test
    files:
      - dv/cpuTb.sv
